// File: hw/decode_dga_pkg.sv
package decode_dga_pkg;

   // control-store operation field
   typedef enum logic [4:0] {
      op_nop  = 5'd0,
      op_wpan = 5'd1,   // write panel word
      op_rpan = 5'd2,   // pop panel fifo
      op_epan = 5'd3,   // panel status onto idb
      op_clrt = 5'd4    // clear rt interrupt
   } idb_op_e;

   // written panel word in its command form
   typedef struct packed {
      logic [3:0] cmd;   // high nibble
      logic [3:0] arg;   // low nibble
   } pan_cmd_s;

   // one idb byte, seen as data or as command
   typedef union packed {
      logic [7:0] raw;
      pan_cmd_s   cmd;
   } pan_word_u;

   localparam logic [3:0] pan_cmd_mcl = 4'hf;   // master clear

   typedef enum logic [1:0] {
      pow_off  = 2'd0,
      pow_wait = 2'd1,   // power-up delay
      pow_run  = 2'd2,
      pow_fail = 2'd3    // power-fail delay
   } pow_state_e;

   // one-cycle strobes out of the decoder
   typedef struct packed {
      logic push;
      logic pop;
      logic epan;
      logic clrt;
   } pan_strobe_s;

   localparam int unsigned pfifo_depth = 8;
   localparam int unsigned pfifo_aw    = 3;

   localparam int unsigned tick_cnt_w = 4;
   localparam logic [tick_cnt_w-1:0] pow_delay = 4'd4;   // xrto ticks
   localparam logic [tick_cnt_w-1:0] rt_period = 4'd6;   // xrto ticks per rt irq

endpackage

// File: hw/idb_decode.sv
`timescale 1ns/100ps

module idb_decode import decode_dga_pkg::*; (
   input  idb_op_e     xid,
   input  pan_word_u   xidb_in,
   input  logic        clear_n,    // low while sequencer clears
   output pan_strobe_s strobe,
   output logic        mcl
);

   logic is_mcl;   // written word carries the master clear command

   // same byte read through its command view
   assign is_mcl = (xidb_in.cmd.cmd == pan_cmd_mcl);

   always_comb begin
      strobe = '0;
      mcl    = 1'b0;
      // nothing decodes while the panel is held clear
      if (clear_n) begin
         case (xid)
            op_wpan: begin
               if (is_mcl)
                  mcl = 1'b1;           // command word, never stored
               else
                  strobe.push = 1'b1;   // plain data byte
            end
            op_rpan: strobe.pop  = 1'b1;
            op_epan: strobe.epan = 1'b1;   // status onto idb this cycle
            op_clrt: strobe.clrt = 1'b1;
            default: ;                     // unused codes act as nop
         endcase
      end
   end

endmodule

// File: hw/pfifo_ctrl.sv
`timescale 1ns/100ps

module pfifo_ctrl import decode_dga_pkg::*; (
   input  logic                xclk,
   input  logic                rst_n,
   input  logic                push,
   input  logic                pop,
   input  logic                flush,
   output logic                wr_en,
   output logic [pfifo_aw-1:0] wr_addr,
   output logic [pfifo_aw-1:0] rd_addr,
   output logic                empty_n,
   output logic                full_n
);

   logic [pfifo_aw-1:0] wr_ptr;
   logic [pfifo_aw-1:0] rd_ptr;
   logic [pfifo_aw:0]   count;   // one extra bit for full
   logic                rd_en;

   // drop push when full and pop when empty
   assign wr_en = push && full_n && !flush;
   assign rd_en = pop && empty_n && !flush;

   assign empty_n = (count != '0);
   assign full_n  = (count != (pfifo_aw+1)'(pfifo_depth));

   assign wr_addr = wr_ptr;
   assign rd_addr = rd_ptr;

   always_ff @(posedge xclk) begin
      if (!rst_n || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

endmodule

// File: hw/pfifo_data.sv
`timescale 1ns/100ps

module pfifo_data import decode_dga_pkg::*; (
   input  logic                xclk,
   input  logic                wr_en,
   input  logic [pfifo_aw-1:0] wr_addr,
   input  logic [pfifo_aw-1:0] rd_addr,
   input  pan_word_u           wdata,
   output pan_word_u           rdata
);

   logic [7:0] mem [pfifo_depth];   // panel byte store

   always_ff @(posedge xclk) begin
      if (wr_en)
         mem[wr_addr] <= wdata.raw;   // data view of the word
   end

   // head word, async read
   assign rdata.raw = mem[rd_addr];

endmodule

// File: hw/pow_seq.sv
`timescale 1ns/100ps

module pow_seq import decode_dga_pkg::*; (
   input  logic       xclk,
   input  logic       rst_n,
   input  logic       xpow,        // power sense
   input  logic       expired,     // delay done
   output logic       start,       // load delay counter
   output logic       run,
   output logic       clear_n,
   output logic       powfail_n,
   output pow_state_e state
);

   pow_state_e state_nxt;

   always_ff @(posedge xclk) begin
      if (!rst_n)
         state <= pow_off;
      else
         state <= state_nxt;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         pow_off: begin
            if (xpow)
               state_nxt = pow_wait;   // power came up
         end
         pow_wait: begin
            if (!xpow)
               state_nxt = pow_off;    // sense lost before run
            else if (expired)
               state_nxt = pow_run;
         end
         pow_run: begin
            if (!xpow)
               state_nxt = pow_fail;
         end
         pow_fail: begin
            // runs its full delay regardless of sense
            if (expired)
               state_nxt = pow_off;
         end
         default: state_nxt = pow_off;
      endcase
   end

   // timer loads on the edge that enters wait or fail
   assign start = (state_nxt != state) &&
                  (state_nxt == pow_wait || state_nxt == pow_fail);

   assign run       = (state == pow_run);
   assign clear_n   = (state == pow_run) || (state == pow_fail);   // clear off until fail ends
   assign powfail_n = (state != pow_fail);

endmodule

// File: hw/rt_timer.sv
`timescale 1ns/100ps

module rt_timer import decode_dga_pkg::*; (
   input  logic xclk,
   input  logic rst_n,
   input  logic tick,      // xrto pulse
   input  logic start,
   input  logic run,
   input  logic clrt,
   output logic expired,
   output logic tout       // rt interrupt
);

   logic [tick_cnt_w-1:0] dly_cnt;   // sequencer delay, counts down
   logic [tick_cnt_w-1:0] per_cnt;   // rt period, counts up
   logic                  dly_act;
   logic                  per_wrap;

   assign expired  = dly_act && (dly_cnt == '0);
   assign per_wrap = run && tick && (per_cnt == rt_period - 1'b1);

   always_ff @(posedge xclk) begin
      if (!rst_n) begin
         dly_cnt <= '0;
         dly_act <= 1'b0;
      end else if (start) begin
         dly_cnt <= pow_delay;
         dly_act <= 1'b1;
      end else if (expired) begin
         dly_act <= 1'b0;   // single pulse per delay
      end else if (dly_act && tick) begin
         dly_cnt <= dly_cnt - 1'b1;
      end
   end

   always_ff @(posedge xclk) begin
      if (!rst_n || !run)
         per_cnt <= '0;   // period restarts with each run
      else if (per_wrap)
         per_cnt <= '0;
      else if (tick)
         per_cnt <= per_cnt + 1'b1;
   end

   always_ff @(posedge xclk) begin
      if (!rst_n || clrt)
         tout <= 1'b0;   // clear beats a coincident set
      else if (per_wrap)
         tout <= 1'b1;
   end

endmodule

// File: hw/decode_dga.sv
`timescale 1ns/100ps

module decode_dga import decode_dga_pkg::*; (
   input  logic       xclk,
   input  logic       rst_n,
   input  logic [4:0] xid,        // control-store idb field
   input  logic [7:0] xidb_in,
   input  logic       xpow,       // power sense level
   input  logic       xrto,       // rt oscillator tick
   input  logic       xrmn,       // head onto xa when low
   output logic [3:0] xidb_out,
   output logic       xepn,
   output logic [7:0] xa,
   output logic       xemn,
   output logic       xfun,
   output logic       xpfn,
   output logic       xcln,
   output logic       xmcl,
   output logic       xtot
);

   pan_strobe_s          strobe;
   logic                 mcl;
   logic                 wr_en;
   logic [pfifo_aw-1:0]  wr_addr;
   logic [pfifo_aw-1:0]  rd_addr;
   logic                 empty_n;
   logic                 full_n;
   pan_word_u            head;
   logic                 start;
   logic                 run;
   logic                 clear_n;
   logic                 powfail_n;
   pow_state_e           pow_state;
   logic                 expired;
   logic                 tout;
   logic [3:0]           status;

   idb_decode idbs (
      .xid     (idb_op_e'(xid)),
      .xidb_in (xidb_in),
      .clear_n (clear_n),
      .strobe  (strobe),
      .mcl     (mcl)
   );

   pfifo_ctrl pfifc (
      .xclk    (xclk),
      .rst_n   (rst_n),
      .push    (strobe.push),
      .pop     (strobe.pop),
      .flush   (mcl),       // master clear empties the fifo
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .rd_addr (rd_addr),
      .empty_n (empty_n),
      .full_n  (full_n)
   );

   pfifo_data pfifd (
      .xclk    (xclk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .rd_addr (rd_addr),
      .wdata   (xidb_in),
      .rdata   (head)
   );

   pow_seq pow (
      .xclk      (xclk),
      .rst_n     (rst_n),
      .xpow      (xpow),
      .expired   (expired),
      .start     (start),
      .run       (run),
      .clear_n   (clear_n),
      .powfail_n (powfail_n),
      .state     (pow_state)
   );

   rt_timer rtt (
      .xclk    (xclk),
      .rst_n   (rst_n),
      .tick    (xrto),
      .start   (start),
      .run     (run),
      .clrt    (strobe.clrt | mcl),   // mcl also drops the rt irq
      .expired (expired),
      .tout    (tout)
   );

   // panel status word, bit 3 always zero
   assign status = {1'b0, pow_state == pow_fail, tout, ~full_n};

   assign xidb_out = strobe.epan ? status : xidb_in[3:0];
   assign xepn     = ~strobe.epan;
   assign xa       = (!xrmn && empty_n) ? head.raw : 8'h00;   // zero unless head enabled
   assign xemn     = empty_n;
   assign xfun     = full_n;
   assign xpfn     = powfail_n;
   assign xcln     = clear_n;
   assign xmcl     = mcl;
   assign xtot     = tout;

endmodule

// File: tests/decode_dga_assert.sv
`timescale 1ns/100ps

module decode_dga_assert (
   input logic       xclk,
   input logic       rst_n,
   input logic       xemn,
   input logic       xfun,
   input logic       xepn,
   input logic [3:0] xidb_out,
   input logic       xrmn,
   input logic [7:0] xa,
   input logic       xmcl
);

   int unsigned err_cnt = 0;   // failures so far, watched by the testbench

   // empty and full never together
   a_flags: assert property (@(posedge xclk) disable iff (!rst_n) xemn || xfun)
      else begin
         $error("fifo shows empty and full at once");
         err_cnt++;
      end

   a_status: assert property (@(posedge xclk) disable iff (!rst_n) !xepn |-> !xidb_out[3])
      else begin
         $error("status bit 3 set while xepn low");
         err_cnt++;
      end

   // head off the bus unless xrmn low
   a_xa_off: assert property (@(posedge xclk) disable iff (!rst_n) xrmn |-> xa == 8'h00)
      else begin
         $error("xa not zero while xrmn high");
         err_cnt++;
      end

   a_mcl_pulse: assert property (@(posedge xclk) disable iff (!rst_n) xmcl |=> !xmcl)
      else begin
         $error("xmcl held longer than one cycle");
         err_cnt++;
      end

endmodule

bind decode_dga decode_dga_assert asrt (.*);

// File: tests/decode_dga_tb.sv
`timescale 1ns/100ps

module decode_dga_tb import decode_dga_pkg::*; ();

   localparam int max_cycles = 600;   // tests need about 70 cycles
   localparam int tick_gap   = 3;     // xclk cycles per xrto tick

   logic       xclk;
   logic       rst_n;
   logic [4:0] xid;
   logic [7:0] xidb_in;
   logic       xpow;
   logic       xrto;
   logic       xrmn;
   logic [3:0] xidb_out;
   logic       xepn;
   logic [7:0] xa;
   logic       xemn;
   logic       xfun;
   logic       xpfn;
   logic       xcln;
   logic       xmcl;
   logic       xtot;
   logic       rto_on;      // tick generator enable
   int         rto_div;
   int         cyc;
   int         seed;
   logic [7:0] model_q[$];  // expected fifo contents, head first
   logic [7:0] byte_v;

   decode_dga dut0 (.*);

   always #5 xclk = ~xclk;

   // one xrto pulse every tick_gap cycles
   always @(posedge xclk) begin
      rto_div <= (rto_div == tick_gap - 1) ? 0 : rto_div + 1;
      xrto    <= rto_on && (rto_div == tick_gap - 1);
   end

   always @(posedge xclk) begin
      cyc <= cyc + 1;
      if (cyc >= max_cycles) begin
         $display("Timeout: run still going after %0d cycles", cyc);
         $display("SOME TESTS FAILED");
         $fatal(1, "timeout");
      end
   end

   always @(negedge xclk) begin
      if (dut0.asrt.err_cnt != 0) begin   // bound assertion fired
         $display("An assertion in decode_dga failed at %0t ns", $time);
         $display("SOME TESTS FAILED");
         $fatal(1, "assertion failure");
      end
   end

   task automatic check_val(input string what, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("SOME TESTS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // one control-store cycle, returns mid-cycle
   task automatic drive_op(input idb_op_e op, input logic [7:0] data);
      @(posedge xclk);
      xid     <= op;
      xidb_in <= data;
      @(negedge xclk);
   endtask

   function automatic logic pick(input string what);
      case (what)
         "xcln":  return xcln;
         default: return xtot;
      endcase
   endfunction

   task automatic wait_level(input string what, input logic lvl, input int max_cyc);
      int n;
      n = 0;
      while (pick(what) !== lvl) begin
         drive_op(op_nop, 8'h00);
         n++;
         if (n > max_cyc) begin
            $display("%s did not reach %b within %0d cycles", what, lvl, max_cyc);
            $display("SOME TESTS FAILED");
            $fatal(1, "wait timed out");
         end
      end
   endtask

   function automatic logic [7:0] rand_byte();
      logic [7:0] b;
      b = 8'($random(seed));
      if (b[7:4] == pan_cmd_mcl)
         b[7] = 1'b0;   // keep it a data byte
      return b;
   endfunction

   initial begin
      xclk    = 1'b0;
      rst_n   = 1'b0;
      xid     = op_nop;
      xidb_in = 8'h00;
      xpow    = 1'b0;
      xrto    = 1'b0;
      xrmn    = 1'b1;
      rto_on  = 1'b0;
      rto_div = 0;
      cyc     = 0;
      seed    = 50;
      repeat (2) @(posedge xclk);
      rst_n <= 1'b1;
      @(negedge xclk);
      check_val("xcln after reset", xcln, 1'b0);
      check_val("xpfn after reset", xpfn, 1'b1);
      check_val("xemn after reset", xemn, 1'b0);
      check_val("xfun after reset", xfun, 1'b1);
      check_val("xtot after reset", xtot, 1'b0);

      // power up
      @(posedge xclk);
      xpow   <= 1'b1;
      rto_on <= 1'b1;
      wait_level("xcln", 1'b1, pow_delay * tick_gap + 2);
      drive_op(op_clrt, 8'h00);   // start with rt irq clear
      @(posedge xclk);
      xrmn <= 1'b0;

      // fill past full, ninth byte dropped
      for (int i = 0; i < pfifo_depth + 1; i++) begin
         byte_v = rand_byte();
         drive_op(op_wpan, byte_v);
         if (model_q.size() < pfifo_depth)
            model_q.push_back(byte_v);
      end
      drive_op(op_nop, 8'h00);
      check_val("xfun when full", xfun, 1'b0);
      check_val("xemn when full", xemn, 1'b1);

      // rt irq and panel status
      wait_level("xtot", 1'b1, rt_period * tick_gap + 2);
      drive_op(op_epan, 8'ha5);
      check_val("xepn on epan", xepn, 1'b0);
      check_val("status nibble", xidb_out, 4'b0011);   // xtot and full
      drive_op(op_clrt, 8'h5a);
      check_val("xepn off epan", xepn, 1'b1);
      check_val("idb pass-through", xidb_out, 4'ha);
      drive_op(op_nop, 8'h00);
      check_val("xtot after clrt", xtot, 1'b0);

      // drain in order
      while (model_q.size() > 0) begin
         drive_op(op_rpan, 8'h00);
         check_val("xa head", xa, model_q.pop_front());
      end
      drive_op(op_nop, 8'h00);
      check_val("xemn after drain", xemn, 1'b0);
      check_val("xa when empty", xa, 8'h00);

      // master clear through a command word
      repeat (3) drive_op(op_wpan, rand_byte());
      wait_level("xtot", 1'b1, rt_period * tick_gap + 2);
      byte_v = {pan_cmd_mcl, 4'($random(seed))};
      drive_op(op_wpan, byte_v);
      check_val("xmcl on command", xmcl, 1'b1);
      drive_op(op_nop, 8'h00);
      check_val("xmcl one cycle later", xmcl, 1'b0);
      check_val("xemn after mcl", xemn, 1'b0);
      check_val("xtot after mcl", xtot, 1'b0);
      check_val("xa after mcl", xa, 8'h00);

      // power fail
      @(posedge xclk);
      xpow <= 1'b0;
      @(posedge xclk);
      @(negedge xclk);
      check_val("xpfn on power loss", xpfn, 1'b0);
      wait_level("xcln", 1'b0, pow_delay * tick_gap + 2);
      check_val("xpfn after power-fail", xpfn, 1'b1);

      if (dut0.asrt.err_cnt == 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         $display("SOME TESTS FAILED");
         $fatal(1, "assertion failures");
      end
   end

endmodule

// File: verilog.f
hw/decode_dga_pkg.sv
hw/idb_decode.sv
hw/pfifo_ctrl.sv
hw/pfifo_data.sv
hw/pow_seq.sv
hw/rt_timer.sv
hw/decode_dga.sv
tests/decode_dga_assert.sv
tests/decode_dga_tb.sv

// File: Bender.yml
package:
  name: decode_dga

sources:
  - files:
      - hw/decode_dga_pkg.sv
      - hw/idb_decode.sv
      - hw/pfifo_ctrl.sv
      - hw/pfifo_data.sv
      - hw/pow_seq.sv
      - hw/rt_timer.sv
      - hw/decode_dga.sv
  - target: test
    files:
      - tests/decode_dga_assert.sv
      - tests/decode_dga_tb.sv
